//--- verilog.f
logic/rename_pkg.sv
logic/issue_if.sv
logic/commit_if.sv
logic/inst_decoder.sv
logic/rename_regfile.sv
logic/reorder_buffer.sv
logic/issue_core.sv
verification/issue_core_assertions.sv
verification/issue_core_checker.sv
verification/issue_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module issue_core_tb -f verilog.f -o issue_core_sim

output=$(./obj_dir/issue_core_sim +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

//--- verification/issue_core_tb.sv
`timescale 1ns/1ps

module issue_core_tb;

    typedef struct {
        logic                  vld;
        rename_pkg::data_t     word;
        logic                  pd;
        logic                  wb;
        rename_pkg::tag_t      wb_tag;
        logic                  flush;
        logic                  ready;
        rename_pkg::op_e       op;
        rename_pkg::reg_name_t rd;
        rename_pkg::data_t     imm;
    } step_t;

    logic                  clk = 1'b0;
    logic                  rst, rdy, clr, instr_valid, pd, wb_en, stall;
    rename_pkg::data_t     instr, wb_data;
    rename_pkg::addr_t     pc;
    rename_pkg::tag_t      wb_tag;
    logic                  dispatch_en, dispatch_pd, commit_en;
    rename_pkg::op_e       dispatch_op, exp_op;
    rename_pkg::addr_t     dispatch_pc;
    rename_pkg::data_t     dispatch_imm, dispatch_rs1_data, dispatch_rs2_data, commit_data;
    rename_pkg::data_t     exp_imm;
    rename_pkg::reg_name_t dispatch_rd, commit_rd, exp_rd;
    rename_pkg::tag_t      dispatch_tag, dispatch_rs1_tag, dispatch_rs2_tag, commit_tag;
    int                    step, checks, errors;
    step_t                 steps [$];

    always #2 clk = ~clk;

    issue_core u_dut (.*);

    issue_core_checker u_checker (.*);

    task automatic add_step(input int vld, input rename_pkg::data_t word, input int pd_bit,
                            input int wb, input int wtag, input int flush, input int ready,
                            input rename_pkg::op_e op, input int rd,
                            input rename_pkg::data_t imm);
        step_t s;
        s.vld    = (vld != 0);
        s.word   = word;
        s.pd     = (pd_bit != 0);
        s.wb     = (wb != 0);
        s.wb_tag = rename_pkg::tag_t'(wtag);
        s.flush  = (flush != 0);
        s.ready  = (ready != 0);
        s.op     = op;
        s.rd     = rename_pkg::reg_name_t'(rd);
        s.imm    = imm;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(1, 32'h0050_0093, 0, 0, 0, 0, 1, rename_pkg::OP_ADDI, 1, 32'd5);
        add_step(1, 32'h0010_8133, 0, 0, 0, 0, 1, rename_pkg::OP_ADD, 2, 32'd0);
        add_step(1, 32'hFFF0_8093, 0, 0, 0, 0, 1, rename_pkg::OP_ADDI, 1, 32'hFFFF_FFFF);
        add_step(1, 32'h0020_A423, 0, 0, 0, 0, 1, rename_pkg::OP_SW, 0, 32'd8);
        add_step(1, 32'hFE20_88E3, 1, 0, 0, 0, 1, rename_pkg::OP_BEQ, 0, 32'hFFFF_FFF0);
        add_step(1, 32'h1234_51B7, 0, 0, 0, 0, 1, rename_pkg::OP_LUI, 3, 32'h1234_5000);
        add_step(1, 32'h0080_026F, 0, 0, 0, 0, 1, rename_pkg::OP_JAL, 4, 32'd8);
        add_step(1, 32'hFFC1_2283, 0, 0, 0, 0, 1, rename_pkg::OP_LW, 5, 32'hFFFF_FFFC);
        // Buffer full, so the sub is offered until a commit frees an entry.
        add_step(1, 32'h4041_0333, 0, 1, 3, 0, 1, rename_pkg::OP_SUB, 6, 32'd0);
        add_step(1, 32'h4041_0333, 0, 1, 2, 0, 1, rename_pkg::OP_SUB, 6, 32'd0);
        add_step(1, 32'h4041_0333, 0, 1, 1, 0, 1, rename_pkg::OP_SUB, 6, 32'd0);
        add_step(1, 32'h4041_0333, 0, 1, 4, 0, 1, rename_pkg::OP_SUB, 6, 32'd0);
        add_step(1, 32'h4041_0333, 0, 0, 0, 0, 1, rename_pkg::OP_SUB, 6, 32'd0);
        add_step(0, 32'h0000_0000, 0, 1, 5, 0, 1, rename_pkg::OP_ILLEGAL, 0, 32'd0);
        add_step(1, 32'h0020_8433, 0, 1, 7, 0, 1, rename_pkg::OP_ADD, 8, 32'd0);
        add_step(0, 32'h0000_0000, 0, 1, 6, 0, 1, rename_pkg::OP_ILLEGAL, 0, 32'd0);
        add_step(1, 32'h0020_8433, 0, 1, 8, 0, 0, rename_pkg::OP_ADD, 8, 32'd0);
        add_step(0, 32'h0000_0000, 0, 1, 8, 0, 1, rename_pkg::OP_ILLEGAL, 0, 32'd0);
        add_step(1, 32'h0020_8433, 0, 0, 0, 1, 1, rename_pkg::OP_ADD, 8, 32'd0);
        add_step(1, 32'h0062_84B3, 0, 0, 0, 0, 1, rename_pkg::OP_ADD, 9, 32'd0);
        add_step(1, 32'h0041_8533, 0, 0, 0, 0, 1, rename_pkg::OP_ADD, 10, 32'd0);
        add_step(0, 32'h0000_0000, 0, 0, 0, 0, 1, rename_pkg::OP_ILLEGAL, 0, 32'd0);
        add_step(0, 32'h0000_0000, 0, 0, 0, 0, 1, rename_pkg::OP_ILLEGAL, 0, 32'd0);
    endtask

    task automatic apply_step(input int i);
        step        = i;
        instr_valid = steps[i].vld;
        instr       = steps[i].word;
        pc          = 32'h0000_1000 + 4 * i;
        pd          = steps[i].pd;
        wb_en       = steps[i].wb;
        wb_tag      = steps[i].wb_tag;
        wb_data     = $urandom;
        clr         = steps[i].flush;
        rdy         = steps[i].ready;
        exp_op      = steps[i].op;
        exp_rd      = steps[i].rd;
        exp_imm     = steps[i].imm;
    endtask

    initial begin
        int prop_fails;
        rst         = 1'b1;
        rdy         = 1'b1;
        clr         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        pd          = 1'b0;
        wb_en       = 1'b0;
        wb_tag      = '0;
        wb_data     = '0;
        step        = -1;
        exp_op      = rename_pkg::OP_ILLEGAL;
        exp_rd      = '0;
        exp_imm     = '0;
        void'($urandom(32'h013f_ffcd));
        build_table();
        fork
            begin
                #(steps.size() * 4 + 200);
                $display("Timeout: the stimulus table did not finish in the allowed time.");
                $display("TEST FAILED");
                $finish;
            end
        join_none
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
            @(posedge clk);
            #1;
        end
        prop_fails = u_dut.u_rob.u_rob_props.fail_count + u_dut.u_regfile.u_rf_props.fail_count;
        $display("Checks %0d, mismatches %0d, assertion failures %0d",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verification/issue_core_checker.sv
`timescale 1ns/1ps

module issue_core_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  int                    step,
    input  logic                  instr_valid, pd, rdy, clr, wb_en,
    input  rename_pkg::data_t     instr, wb_data,
    input  rename_pkg::addr_t     pc,
    input  rename_pkg::tag_t      wb_tag,
    input  rename_pkg::op_e       exp_op,
    input  rename_pkg::reg_name_t exp_rd,
    input  rename_pkg::data_t     exp_imm,
    input  logic                  stall, dispatch_en, dispatch_pd, commit_en,
    input  rename_pkg::op_e       dispatch_op,
    input  rename_pkg::addr_t     dispatch_pc,
    input  rename_pkg::data_t     dispatch_imm, dispatch_rs1_data, dispatch_rs2_data,
    input  rename_pkg::data_t     commit_data,
    input  rename_pkg::reg_name_t dispatch_rd, commit_rd,
    input  rename_pkg::tag_t      dispatch_tag, dispatch_rs1_tag, dispatch_rs2_tag, commit_tag,
    output int                    checks,
    output int                    errors
);

    rename_pkg::data_t     m_data [rename_pkg::REG_COUNT];
    rename_pkg::tag_t      m_tag  [rename_pkg::REG_COUNT];
    rename_pkg::reg_name_t q_rd   [rename_pkg::ROB_DEPTH];
    rename_pkg::data_t     q_data [rename_pkg::ROB_DEPTH];
    logic                  q_done [rename_pkg::ROB_DEPTH];
    int                    head, tail, count, step_errors;
    logic                  exp_disp;
    logic [151:0]          exp_rec;   // Dispatch record expected in the next cycle.

    task automatic expect_eq(input string what, input logic [151:0] got,
                             input logic [151:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            step_errors++;
            $display("FAIL @%0t %s: got %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // Source read with forwarding from a matching commit.
    function automatic logic [35:0] read_src(input rename_pkg::reg_name_t r, input logic fwd);
        if (r == '0) return '0;
        if (fwd && q_rd[head] == r && m_tag[r] == rename_pkg::tag_t'(head + 1))
            return {q_data[head], 4'h0};
        return {m_data[r], m_tag[r]};
    endfunction

    always @(negedge clk) begin
        logic             want_commit;
        logic             issue;
        logic [35:0]      src1;
        logic [35:0]      src2;
        rename_pkg::tag_t c_tag;
        if (rst) begin
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                m_data[i] = '0;
                m_tag[i]  = '0;
            end
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) q_done[i] = 1'b0;
            head = 0;
            tail = 0;
            count = 0;
            exp_disp = 1'b0;
            checks = 0;
            errors = 0;
            step_errors = 0;
        end else begin
            want_commit = rdy && count != 0 && q_done[head];
            c_tag = rename_pkg::tag_t'(head + 1);
            expect_eq("stall", stall, count == rename_pkg::ROB_DEPTH);
            expect_eq("dispatch_en", dispatch_en, exp_disp);
            if (exp_disp) begin
                expect_eq("dispatch record", {dispatch_op, dispatch_pc, dispatch_imm,
                          dispatch_pd, dispatch_rd, dispatch_tag, dispatch_rs1_data,
                          dispatch_rs2_data, dispatch_rs1_tag, dispatch_rs2_tag}, exp_rec);
            end
            expect_eq("commit_en", commit_en, want_commit);
            if (want_commit) begin
                expect_eq("commit", {commit_rd, commit_data, commit_tag},
                          {q_rd[head], q_data[head], c_tag});
            end
            issue = instr_valid && rdy && !clr && count != rename_pkg::ROB_DEPTH;
            src1 = read_src(instr[19:15], want_commit);
            src2 = read_src(instr[24:20], want_commit);
            exp_disp = issue;
            if (issue) begin
                exp_rec = {exp_op, pc, exp_imm, pd, exp_rd, rename_pkg::tag_t'(tail + 1),
                           src1[35:4], src2[35:4], src1[3:0], src2[3:0]};
            end
            if (want_commit) begin
                if (q_rd[head] != '0) m_data[q_rd[head]] = q_data[head];
                if (m_tag[q_rd[head]] == c_tag) m_tag[q_rd[head]] = '0;
                q_done[head] = 1'b0;
                head = (head + 1) % rename_pkg::ROB_DEPTH;
                count--;
            end
            if (rdy && wb_en && wb_tag != '0) begin
                q_done[wb_tag - 1] = 1'b1;
                q_data[wb_tag - 1] = wb_data;
            end
            if (issue) begin
                if (exp_rd != '0) m_tag[exp_rd] = rename_pkg::tag_t'(tail + 1);
                q_rd[tail]   = exp_rd;
                q_done[tail] = 1'b0;
                tail = (tail + 1) % rename_pkg::ROB_DEPTH;
                count++;
            end
            if (clr) begin
                for (int i = 0; i < rename_pkg::REG_COUNT; i++) m_tag[i] = '0;
                for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) q_done[i] = 1'b0;
                head = 0;
                tail = 0;
                count = 0;
            end
            if (step >= 0) begin
                $display("step %0d: %s", step, (step_errors == 0) ? "ok" : "mismatch");
                step_errors = 0;
            end
        end
    end

endmodule

//--- verification/issue_core_assertions.sv
`timescale 1ns/1ps

module issue_core_assertions (
    input logic             clk,
    input logic             rst,
    input logic             full,
    input logic             issue_en,
    input logic             commit_en,
    input logic             rob_empty,
    input rename_pkg::tag_t reg0_tag
);

    int fail_count = 0;

    no_issue_when_full: assert property (@(posedge clk) disable iff (rst) !(full && issue_en))
        else begin
            $error("issue accepted while the reorder buffer is full");
            fail_count++;
        end

    no_commit_when_empty: assert property (@(posedge clk) disable iff (rst)
                                           !(commit_en && rob_empty))
        else begin
            $error("commit raised while the reorder buffer is empty");
            fail_count++;
        end

    reg0_never_renamed: assert property (@(posedge clk) disable iff (rst) reg0_tag == '0)
        else begin
            $error("register zero holds a rename tag");
            fail_count++;
        end

endmodule

bind reorder_buffer issue_core_assertions u_rob_props (
    .clk       (clk),
    .rst       (rst),
    .full      (full),
    .issue_en  (issue.en),
    .commit_en (commit.en),
    .rob_empty ((head == tail) && !full),
    .reg0_tag  (4'h0)
);

// Only the register zero check applies here.
bind rename_regfile issue_core_assertions u_rf_props (
    .clk       (clk),
    .rst       (rst),
    .full      (1'b0),
    .issue_en  (issue.en),
    .commit_en (1'b0),
    .rob_empty (1'b0),
    .reg0_tag  (reg_tag[0])
);

//--- logic/issue_core.sv
`timescale 1ns/1ps

module issue_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  clr,
    input  logic                  instr_valid,
    input  rename_pkg::data_t     instr,
    input  rename_pkg::addr_t     pc,
    input  logic                  pd,
    output logic                  stall,
    input  logic                  wb_en,
    input  rename_pkg::tag_t      wb_tag,
    input  rename_pkg::data_t     wb_data,
    output logic                  dispatch_en,
    output rename_pkg::op_e       dispatch_op,
    output rename_pkg::addr_t     dispatch_pc,
    output rename_pkg::data_t     dispatch_imm,
    output logic                  dispatch_pd,
    output rename_pkg::reg_name_t dispatch_rd,
    output rename_pkg::tag_t      dispatch_tag,
    output rename_pkg::data_t     dispatch_rs1_data,
    output rename_pkg::data_t     dispatch_rs2_data,
    output rename_pkg::tag_t      dispatch_rs1_tag,
    output rename_pkg::tag_t      dispatch_rs2_tag,
    output logic                  commit_en,
    output rename_pkg::reg_name_t commit_rd,
    output rename_pkg::data_t     commit_data,
    output rename_pkg::tag_t      commit_tag
);

    issue_if          issue_bus ();
    commit_if         commit_bus ();
    rename_pkg::tag_t alloc_tag;

    inst_decoder u_decoder (
        .instr       (instr),
        .pc          (pc),
        .pd          (pd),
        .instr_valid (instr_valid),
        .rdy         (rdy),
        .clr         (clr),
        .full        (stall),     // Buffer full is the only back-pressure.
        .issue       (issue_bus.decoder)
    );

    rename_regfile u_regfile (
        .clk               (clk),
        .rst               (rst),
        .clr               (clr),
        .issue             (issue_bus.regfile),
        .alloc_tag         (alloc_tag),
        .commit            (commit_bus.regfile),
        .dispatch_en       (dispatch_en),
        .dispatch_op       (dispatch_op),
        .dispatch_pc       (dispatch_pc),
        .dispatch_imm      (dispatch_imm),
        .dispatch_pd       (dispatch_pd),
        .dispatch_rd       (dispatch_rd),
        .dispatch_tag      (dispatch_tag),
        .dispatch_rs1_data (dispatch_rs1_data),
        .dispatch_rs2_data (dispatch_rs2_data),
        .dispatch_rs1_tag  (dispatch_rs1_tag),
        .dispatch_rs2_tag  (dispatch_rs2_tag)
    );

    reorder_buffer u_rob (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .clr       (clr),
        .issue     (issue_bus.rob),
        .alloc_tag (alloc_tag),
        .full      (stall),
        .wb_en     (wb_en),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data),
        .commit    (commit_bus.rob)
    );

    assign commit_en   = commit_bus.en;
    assign commit_rd   = commit_bus.rd;
    assign commit_data = commit_bus.data;
    assign commit_tag  = commit_bus.tag;

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              clr,
    issue_if.rob              issue,
    output rename_pkg::tag_t  alloc_tag,
    output logic              full,
    input  logic              wb_en,
    input  rename_pkg::tag_t  wb_tag,
    input  rename_pkg::data_t wb_data,
    commit_if.rob             commit
);

    logic [rename_pkg::ROB_PTR_W-1:0] head;
    logic [rename_pkg::ROB_PTR_W-1:0] tail;
    logic [rename_pkg::ROB_PTR_W:0]   count;

    logic [rename_pkg::ROB_DEPTH-1:0] entry_done;
    rename_pkg::reg_name_t            entry_rd   [rename_pkg::ROB_DEPTH];
    rename_pkg::data_t                entry_data [rename_pkg::ROB_DEPTH];

    rename_pkg::tag_t                 wb_dec;
    logic [rename_pkg::ROB_PTR_W-1:0] wb_idx;
    logic                             wb_accept;

    // Tags are the entry index plus one, so zero stays free.
    assign alloc_tag = {1'b0, tail} + 1'b1;
    assign full      = (int'(count) == rename_pkg::ROB_DEPTH);

    assign wb_dec    = wb_tag - 1'b1;
    assign wb_idx    = wb_dec[rename_pkg::ROB_PTR_W-1:0];
    assign wb_accept = rdy && wb_en && (wb_tag != '0);

    assign commit.en   = rdy && (count != '0) && entry_done[head];
    assign commit.rd   = entry_rd[head];
    assign commit.data = entry_data[head];
    assign commit.tag  = {1'b0, head} + 1'b1;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            entry_done <= '0;
        end else begin
            if (commit.en) begin
                entry_done[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            if (wb_accept) begin
                entry_done[wb_idx] <= 1'b1;
            end
            if (issue.en) begin
                entry_done[tail] <= 1'b0;   // Fresh entry waits for its result.
                tail             <= tail + 1'b1;
            end
            case ({issue.en, commit.en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload.
    always_ff @(posedge clk) begin
        if (wb_accept) begin
            entry_data[wb_idx] <= wb_data;
        end
        if (issue.en) begin
            entry_rd[tail] <= issue.rd;
        end
    end

endmodule

//--- logic/rename_regfile.sv
`timescale 1ns/1ps

module rename_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    issue_if.regfile              issue,
    input  rename_pkg::tag_t      alloc_tag,
    commit_if.regfile             commit,
    output logic                  dispatch_en,
    output rename_pkg::op_e       dispatch_op,
    output rename_pkg::addr_t     dispatch_pc,
    output rename_pkg::data_t     dispatch_imm,
    output logic                  dispatch_pd,
    output rename_pkg::reg_name_t dispatch_rd,
    output rename_pkg::tag_t      dispatch_tag,
    output rename_pkg::data_t     dispatch_rs1_data,
    output rename_pkg::data_t     dispatch_rs2_data,
    output rename_pkg::tag_t      dispatch_rs1_tag,
    output rename_pkg::tag_t      dispatch_rs2_tag
);

    rename_pkg::data_t reg_data [rename_pkg::REG_COUNT];
    rename_pkg::tag_t  reg_tag  [rename_pkg::REG_COUNT];

    rename_pkg::data_t rs1_data;
    rename_pkg::data_t rs2_data;
    rename_pkg::tag_t  rs1_tag;
    rename_pkg::tag_t  rs2_tag;

    // The committing result is the one this register waits for.
    function automatic logic fwd_hit(input rename_pkg::reg_name_t name);
        return commit.en && (commit.rd == name) && (commit.tag == reg_tag[name]);
    endfunction

    function automatic rename_pkg::data_t read_data(input rename_pkg::reg_name_t name);
        if (name == '0) return '0;
        if (fwd_hit(name)) return commit.data;
        return reg_data[name];
    endfunction

    function automatic rename_pkg::tag_t read_tag(input rename_pkg::reg_name_t name);
        if (name == '0 || fwd_hit(name)) return '0;
        return reg_tag[name];
    endfunction

    always_comb begin
        rs1_data = read_data(issue.rs1);
        rs2_data = read_data(issue.rs2);
        rs1_tag  = read_tag(issue.rs1);
        rs2_tag  = read_tag(issue.rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                reg_data[i] <= '0;
                reg_tag[i]  <= '0;
            end
        end else begin
            // Committed data always land, flush or not.
            if (commit.en && commit.rd != '0) begin
                reg_data[commit.rd] <= commit.data;
            end
            if (clr) begin
                for (int i = 0; i < rename_pkg::REG_COUNT; i++) begin
                    reg_tag[i] <= '0;
                end
            end else begin
                if (commit.en && commit.tag == reg_tag[commit.rd]) begin
                    reg_tag[commit.rd] <= '0;
                end
                // A new rename overrides a same-cycle clear.
                if (issue.en && issue.rd != '0) begin
                    reg_tag[issue.rd] <= alloc_tag;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) dispatch_en <= 1'b0;
        else     dispatch_en <= issue.en;
    end

    always_ff @(posedge clk) begin
        if (issue.en) begin
            dispatch_op       <= issue.op;
            dispatch_pc       <= issue.pc;
            dispatch_imm      <= issue.imm;
            dispatch_pd       <= issue.pd;
            dispatch_rd       <= issue.rd;
            dispatch_tag      <= alloc_tag;   // The instruction's own buffer entry.
            dispatch_rs1_data <= rs1_data;
            dispatch_rs2_data <= rs2_data;
            dispatch_rs1_tag  <= rs1_tag;
            dispatch_rs2_tag  <= rs2_tag;
        end
    end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  rename_pkg::data_t instr,
    input  rename_pkg::addr_t pc,
    input  logic              pd,
    input  logic              instr_valid,
    input  logic              rdy,
    input  logic              clr,
    input  logic              full,
    issue_if.decoder          issue
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rename_pkg::data_t imm_i;
    rename_pkg::data_t imm_s;
    rename_pkg::data_t imm_b;
    rename_pkg::data_t imm_u;
    rename_pkg::data_t imm_j;
    rename_pkg::op_e   op;
    rename_pkg::data_t imm;
    logic              no_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op    = rename_pkg::OP_ILLEGAL;
        imm   = '0;
        no_rd = 1'b0;
        case (opcode)
            rename_pkg::OPC_LUI: begin
                op  = rename_pkg::OP_LUI;
                imm = imm_u;
            end
            rename_pkg::OPC_AUIPC: begin
                op  = rename_pkg::OP_AUIPC;
                imm = imm_u;
            end
            rename_pkg::OPC_JAL: begin
                op  = rename_pkg::OP_JAL;
                imm = imm_j;
            end
            rename_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) op = rename_pkg::OP_JALR;
                imm = imm_i;
            end
            rename_pkg::OPC_BRANCH: begin
                imm   = imm_b;
                no_rd = 1'b1;        // Bits 11:7 are part of the offset.
                case (funct3)
                    3'b000:  op = rename_pkg::OP_BEQ;
                    3'b001:  op = rename_pkg::OP_BNE;
                    3'b100:  op = rename_pkg::OP_BLT;
                    3'b101:  op = rename_pkg::OP_BGE;
                    3'b110:  op = rename_pkg::OP_BLTU;
                    3'b111:  op = rename_pkg::OP_BGEU;
                    default: op = rename_pkg::OP_ILLEGAL;
                endcase
            end
            rename_pkg::OPC_LOAD: begin
                imm = imm_i;
                case (funct3)
                    3'b000:  op = rename_pkg::OP_LB;
                    3'b001:  op = rename_pkg::OP_LH;
                    3'b010:  op = rename_pkg::OP_LW;
                    3'b100:  op = rename_pkg::OP_LBU;
                    3'b101:  op = rename_pkg::OP_LHU;
                    default: op = rename_pkg::OP_ILLEGAL;
                endcase
            end
            rename_pkg::OPC_STORE: begin
                imm   = imm_s;
                no_rd = 1'b1;
                case (funct3)
                    3'b000:  op = rename_pkg::OP_SB;
                    3'b001:  op = rename_pkg::OP_SH;
                    3'b010:  op = rename_pkg::OP_SW;
                    default: op = rename_pkg::OP_ILLEGAL;
                endcase
            end
            rename_pkg::OPC_OP_IMM: begin
                imm = imm_i;
                case (funct3)
                    3'b000: op = rename_pkg::OP_ADDI;
                    3'b010: op = rename_pkg::OP_SLTI;
                    3'b011: op = rename_pkg::OP_SLTIU;
                    3'b100: op = rename_pkg::OP_XORI;
                    3'b110: op = rename_pkg::OP_ORI;
                    3'b111: op = rename_pkg::OP_ANDI;
                    3'b001: if (funct7 == 7'b0000000) op = rename_pkg::OP_SLLI;
                    default: begin
                        if (funct7 == 7'b0000000) op = rename_pkg::OP_SRLI;
                        else if (funct7 == 7'b0100000) op = rename_pkg::OP_SRAI;
                    end
                endcase
            end
            rename_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = rename_pkg::OP_ADD;
                    10'b0100000_000: op = rename_pkg::OP_SUB;
                    10'b0000000_001: op = rename_pkg::OP_SLL;
                    10'b0000000_010: op = rename_pkg::OP_SLT;
                    10'b0000000_011: op = rename_pkg::OP_SLTU;
                    10'b0000000_100: op = rename_pkg::OP_XOR;
                    10'b0000000_101: op = rename_pkg::OP_SRL;
                    10'b0100000_101: op = rename_pkg::OP_SRA;
                    10'b0000000_110: op = rename_pkg::OP_OR;
                    10'b0000000_111: op = rename_pkg::OP_AND;
                    default:         op = rename_pkg::OP_ILLEGAL;
                endcase
            end
            default: op = rename_pkg::OP_ILLEGAL;
        endcase
    end

    // An offered instruction is dropped while the buffer is full.
    assign issue.en  = instr_valid && rdy && !full && !clr;
    assign issue.rs1 = instr[19:15];
    assign issue.rs2 = instr[24:20];
    assign issue.rd  = no_rd ? '0 : instr[11:7];
    assign issue.op  = op;
    assign issue.pc  = pc;
    assign issue.imm = imm;
    assign issue.pd  = pd;

endmodule

//--- logic/commit_if.sv
`timescale 1ns/1ps

interface commit_if;
    logic                  en;
    rename_pkg::reg_name_t rd;
    rename_pkg::data_t     data;
    rename_pkg::tag_t      tag;

    modport rob (output en, rd, data, tag);

    modport regfile (input en, rd, data, tag);
endinterface

//--- logic/issue_if.sv
`timescale 1ns/1ps

interface issue_if;
    logic                  en;   // One strobe per issued instruction.
    rename_pkg::reg_name_t rs1;
    rename_pkg::reg_name_t rs2;
    rename_pkg::reg_name_t rd;   // Zero for stores and branches.
    rename_pkg::op_e       op;
    rename_pkg::addr_t     pc;
    rename_pkg::data_t     imm;
    logic                  pd;

    modport decoder (output en, rs1, rs2, rd, op, pc, imm, pd);

    modport regfile (input en, rs1, rs2, rd, op, pc, imm, pd);

    modport rob (input en, rd);
endinterface

//--- logic/rename_pkg.sv
package rename_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_name_t;
    typedef logic [3:0]  tag_t;     // Zero means the register file holds the value.

    localparam int unsigned REG_COUNT = 32;
    localparam int unsigned ROB_DEPTH = 8;
    localparam int unsigned ROB_PTR_W = 3;

    // Major opcodes of RV32I.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [5:0] {
        OP_ILLEGAL,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_e;

endpackage
